//--- design/exec_pkg.sv
package exec_pkg;

    // ------------------------------------------------
    // widths.
    // ------------------------------------------------
    localparam int DATA_WIDTH = 64;
    localparam int ADDR_WIDTH = 64;
    localparam int REG_ADDR_W = 5;

    // ------------------------------------------------
    // opcodes.
    // ------------------------------------------------

    // alu operations, shifts use the low 6 bits of operand b.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLL  = 4'b0010,
        ALU_SLT  = 4'b0011,
        ALU_SLTU = 4'b0100,
        ALU_XOR  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SRA  = 4'b0111,
        ALU_OR   = 4'b1000,
        ALU_AND  = 4'b1001
    } alu_op_e;

    // branch conditions, encoded as the risc-v func3 field.
    // codes 2 and 3 are unused and never branch.
    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd4,
        BR_GE  = 3'd5,
        BR_LTU = 3'd6,
        BR_GEU = 3'd7
    } branch_cond_e;

    // ------------------------------------------------
    // micro-op and result.
    // ------------------------------------------------

    // decoded micro-op with resolved operands.
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] rs1_data;
        logic [DATA_WIDTH-1:0] rs2_data;
        logic [DATA_WIDTH-1:0] imm_ext;
        logic [REG_ADDR_W-1:0] rd_addr;
        alu_op_e               alu_op;
        branch_cond_e          func3;
        // immediate as operand b.
        logic                  alu_src;
        logic                  branch;
        logic                  jump;
        // 0 selects pc + imm, 1 selects alu sum with bit 0 cleared.
        logic                  pc_target_src;
        logic                  reg_we;
        logic                  mem_we;
    } uop_t;

    // registered execute result.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] alu_result;
        // rs2 passed on for stores.
        logic [DATA_WIDTH-1:0] write_data;
        logic [ADDR_WIDTH-1:0] pc_plus4;
        logic [ADDR_WIDTH-1:0] pc_target;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  pc_src;
        logic                  reg_we;
        logic                  mem_we;
    } exec_result_t;

endpackage

//--- design/alu.sv
module alu (
    input  exec_pkg::alu_op_e                i_alu_op,
    input  logic [exec_pkg::DATA_WIDTH-1:0]  i_src_1,
    input  logic [exec_pkg::DATA_WIDTH-1:0]  i_src_2,
    output logic [exec_pkg::DATA_WIDTH-1:0]  o_alu_result,
    output logic                             o_zero_flag,
    output logic                             o_lt_flag,
    output logic                             o_ltu_flag
);

    localparam int DW      = exec_pkg::DATA_WIDTH;
    localparam int SHAMT_W = $clog2(DW);

    // ------------------------------------------------
    // internal nets.
    // ------------------------------------------------
    logic [SHAMT_W-1:0] s_shamt;
    logic [DW-1:0]      s_sum;
    logic [DW-1:0]      s_diff;

    assign s_shamt = i_src_2[SHAMT_W-1:0];
    assign s_sum   = i_src_1 + i_src_2;
    assign s_diff  = i_src_1 - i_src_2;

    // compare flags, independent of the operation.
    assign o_lt_flag  = $signed(i_src_1) < $signed(i_src_2);
    assign o_ltu_flag = i_src_1 < i_src_2;

    // ------------------------------------------------
    // operation select.
    // ------------------------------------------------
    always_comb begin
        case (i_alu_op)
            exec_pkg::ALU_ADD: begin
                o_alu_result = s_sum;
            end
            exec_pkg::ALU_SUB: begin
                o_alu_result = s_diff;
            end
            exec_pkg::ALU_SLL: begin
                o_alu_result = i_src_1 << s_shamt;
            end
            exec_pkg::ALU_SLT: begin
                o_alu_result = {{(DW-1){1'b0}}, o_lt_flag};
            end
            exec_pkg::ALU_SLTU: begin
                o_alu_result = {{(DW-1){1'b0}}, o_ltu_flag};
            end
            exec_pkg::ALU_XOR: begin
                o_alu_result = i_src_1 ^ i_src_2;
            end
            exec_pkg::ALU_SRL: begin
                o_alu_result = i_src_1 >> s_shamt;
            end
            exec_pkg::ALU_SRA: begin
                // arithmetic, sign bit fills from the left.
                o_alu_result = $signed(i_src_1) >>> s_shamt;
            end
            exec_pkg::ALU_OR: begin
                o_alu_result = i_src_1 | i_src_2;
            end
            exec_pkg::ALU_AND: begin
                o_alu_result = i_src_1 & i_src_2;
            end
            default: begin
                o_alu_result = '0;
            end
        endcase
    end

    // zero flag on the selected result.
    assign o_zero_flag = (o_alu_result == '0);

endmodule

//--- design/exec_lane.sv
module exec_lane (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // micro-op from dispatch.
    input  logic                   i_valid,
    input  exec_pkg::uop_t         i_uop,
    output logic                   o_ready,

    // result to merger.
    input  logic                   i_take,
    output logic                   o_valid,
    output exec_pkg::exec_result_t o_res
);

    localparam int DW = exec_pkg::DATA_WIDTH;
    localparam int AW = exec_pkg::ADDR_WIDTH;

    // ------------------------------------------------
    // internal nets.
    // ------------------------------------------------
    logic [DW-1:0]          s_src_b;
    logic [DW-1:0]          s_alu_result;
    logic                   s_zero_flag;
    logic                   s_lt_flag;
    logic                   s_ltu_flag;
    logic [AW-1:0]          s_pc_plus_imm;
    logic [AW-1:0]          s_alu_target;
    logic                   s_cond;
    logic                   s_load;
    exec_pkg::exec_result_t s_res;
    exec_pkg::exec_result_t r_res;
    logic                   r_valid;

    // operand b is register or immediate.
    assign s_src_b = i_uop.alu_src ? i_uop.imm_ext : i_uop.rs2_data;

    alu alu_i (
        .i_alu_op     (i_uop.alu_op),
        .i_src_1      (i_uop.rs1_data),
        .i_src_2      (s_src_b),
        .o_alu_result (s_alu_result),
        .o_zero_flag  (s_zero_flag),
        .o_lt_flag    (s_lt_flag),
        .o_ltu_flag   (s_ltu_flag)
    );

    // jump target candidates.
    assign s_pc_plus_imm = i_uop.pc + AW'(i_uop.imm_ext);
    assign s_alu_target  = {s_alu_result[AW-1:1], 1'b0};

    // branch condition from func3 and flags.
    always_comb begin
        case (i_uop.func3)
            exec_pkg::BR_EQ:  s_cond = s_zero_flag;
            exec_pkg::BR_NE:  s_cond = ~s_zero_flag;
            exec_pkg::BR_LT:  s_cond = s_lt_flag;
            exec_pkg::BR_GE:  s_cond = ~s_lt_flag;
            exec_pkg::BR_LTU: s_cond = s_ltu_flag;
            exec_pkg::BR_GEU: s_cond = ~s_ltu_flag;
            default:          s_cond = 1'b0;
        endcase
    end

    // next result value.
    always_comb begin
        s_res.alu_result = s_alu_result;
        s_res.write_data = i_uop.rs2_data;
        s_res.pc_plus4   = i_uop.pc + AW'(4);
        s_res.pc_target  = i_uop.pc_target_src ? s_alu_target : s_pc_plus_imm;
        s_res.rd_addr    = i_uop.rd_addr;
        s_res.pc_src     = i_uop.jump | (i_uop.branch & s_cond);
        s_res.reg_we     = i_uop.reg_we;
        s_res.mem_we     = i_uop.mem_we;
    end

    // ------------------------------------------------
    // pipeline register.
    // ------------------------------------------------

    // free when empty or being drained this cycle.
    assign o_ready = ~r_valid | i_take;
    assign s_load  = i_valid & o_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_valid <= 1'b0;
        end else if (s_load) begin
            r_valid <= 1'b1;
        end else if (i_take) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s_load) begin
            r_res <= s_res;
        end
    end

    assign o_valid = r_valid;
    assign o_res   = r_res;

    // the merger only takes a full lane.
    a_take_when_valid : assert property (
        @(posedge i_clk) disable iff (i_rst) i_take |-> o_valid
    );

endmodule

//--- design/dispatch_unit.sv
module dispatch_unit #(
    parameter int NUM_LANES = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst,

    // incoming micro-op stream.
    input  logic                 i_uop_valid,
    input  exec_pkg::uop_t       i_uop,
    output logic                 o_uop_ready,

    // lane side.
    output logic [NUM_LANES-1:0] o_lane_valid,
    output exec_pkg::uop_t       o_lane_uop,
    input  logic [NUM_LANES-1:0] i_lane_ready
);

    localparam int PTR_W = $clog2(NUM_LANES);

    logic [PTR_W-1:0] r_ptr;
    logic             s_xfer;

    // only the pointed lane sees a valid.
    always_comb begin
        o_lane_valid        = '0;
        o_lane_valid[r_ptr] = i_uop_valid;
    end

    // micro-op goes to all lanes and the valid picks one.
    assign o_lane_uop  = i_uop;
    assign o_uop_ready = i_lane_ready[r_ptr];
    assign s_xfer      = i_uop_valid & o_uop_ready;

    // ------------------------------------------------
    // round-robin pointer.
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_ptr <= '0;
        end else if (s_xfer) begin
            if (r_ptr == PTR_W'(NUM_LANES - 1)) begin
                r_ptr <= '0;
            end else begin
                r_ptr <= r_ptr + 1'b1;
            end
        end
    end

    // the pointed lane is full only when every lane is full.
    a_stall_only_when_full : assert property (
        @(posedge i_clk) disable iff (i_rst) !o_uop_ready |-> (i_lane_ready == '0)
    );

endmodule

//--- design/result_merger.sv
module result_merger #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst,

    // lane side.
    input  logic [NUM_LANES-1:0]                   i_lane_valid,
    input  exec_pkg::exec_result_t [NUM_LANES-1:0] i_lane_res,
    output logic [NUM_LANES-1:0]                   o_lane_take,

    // outgoing result stream.
    output logic                                   o_res_valid,
    output exec_pkg::exec_result_t                 o_res,
    input  logic                                   i_res_ready
);

    localparam int PTR_W = $clog2(NUM_LANES);

    logic [PTR_W-1:0] r_ptr;
    logic             s_xfer;

    // present the lane at the drain pointer.
    assign o_res_valid = i_lane_valid[r_ptr];
    assign o_res       = i_lane_res[r_ptr];
    assign s_xfer      = o_res_valid & i_res_ready;

    always_comb begin
        o_lane_take        = '0;
        o_lane_take[r_ptr] = s_xfer;
    end

    // ------------------------------------------------
    // drain pointer, same order as dispatch.
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_ptr <= '0;
        end else if (s_xfer) begin
            if (r_ptr == PTR_W'(NUM_LANES - 1)) begin
                r_ptr <= '0;
            end else begin
                r_ptr <= r_ptr + 1'b1;
            end
        end
    end

    // a stalled result must hold until accepted.
    a_res_stable : assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res))
    );

endmodule

//--- design/exec_cluster.sv
module exec_cluster #(
    parameter int NUM_LANES = 4
) (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // micro-op input stream.
    input  logic                   i_uop_valid,
    input  exec_pkg::uop_t         i_uop,
    output logic                   o_uop_ready,

    // result output stream.
    output logic                   o_res_valid,
    output exec_pkg::exec_result_t o_res,
    input  logic                   i_res_ready
);

    // ------------------------------------------------
    // lane nets.
    // ------------------------------------------------
    logic [NUM_LANES-1:0]                   s_lane_in_valid;
    exec_pkg::uop_t                         s_lane_uop;
    logic [NUM_LANES-1:0]                   s_lane_ready;
    logic [NUM_LANES-1:0]                   s_lane_out_valid;
    exec_pkg::exec_result_t [NUM_LANES-1:0] s_lane_res;
    logic [NUM_LANES-1:0]                   s_lane_take;

    dispatch_unit #(
        .NUM_LANES (NUM_LANES)
    ) dispatch_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_uop_valid  (i_uop_valid),
        .i_uop        (i_uop),
        .o_uop_ready  (o_uop_ready),
        .o_lane_valid (s_lane_in_valid),
        .o_lane_uop   (s_lane_uop),
        .i_lane_ready (s_lane_ready)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane lane_i (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_valid (s_lane_in_valid[g]),
            .i_uop   (s_lane_uop),
            .o_ready (s_lane_ready[g]),
            .i_take  (s_lane_take[g]),
            .o_valid (s_lane_out_valid[g]),
            .o_res   (s_lane_res[g])
        );
    end

    result_merger #(
        .NUM_LANES (NUM_LANES)
    ) merger_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_lane_valid (s_lane_out_valid),
        .i_lane_res   (s_lane_res),
        .o_lane_take  (s_lane_take),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .i_res_ready  (i_res_ready)
    );

endmodule

//--- tests/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// expected results, oldest first.
exec_pkg::exec_result_t expected_q[$];

// alu value from the isa definition of each operation.
function automatic logic [63:0] calc_alu(input exec_pkg::alu_op_e op,
                                         input logic [63:0] a,
                                         input logic [63:0] b);
    logic [5:0] shamt;
    shamt = b[5:0];
    case (op)
        exec_pkg::ALU_ADD:  return a + b;
        exec_pkg::ALU_SUB:  return a - b;
        exec_pkg::ALU_SLL:  return a << shamt;
        exec_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        exec_pkg::ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
        exec_pkg::ALU_XOR:  return a ^ b;
        exec_pkg::ALU_SRL:  return a >> shamt;
        exec_pkg::ALU_SRA:  return $unsigned($signed(a) >>> shamt);
        exec_pkg::ALU_OR:   return a | b;
        exec_pkg::ALU_AND:  return a & b;
        default:            return 64'd0;
    endcase
endfunction

// branch outcome straight from the operand compare.
function automatic logic branch_taken(input exec_pkg::branch_cond_e cond,
                                      input logic [63:0] a,
                                      input logic [63:0] b);
    case (cond)
        exec_pkg::BR_EQ:  return a == b;
        exec_pkg::BR_NE:  return a != b;
        exec_pkg::BR_LT:  return $signed(a) < $signed(b);
        exec_pkg::BR_GE:  return $signed(a) >= $signed(b);
        exec_pkg::BR_LTU: return a < b;
        exec_pkg::BR_GEU: return a >= b;
        default:          return 1'b0;
    endcase
endfunction

function automatic exec_pkg::exec_result_t expected_result(input exec_pkg::uop_t uop);
    logic [63:0]            src_b;
    exec_pkg::exec_result_t r;
    src_b        = uop.alu_src ? uop.imm_ext : uop.rs2_data;
    r.alu_result = calc_alu(uop.alu_op, uop.rs1_data, src_b);
    r.write_data = uop.rs2_data;
    r.pc_plus4   = uop.pc + 64'd4;
    r.pc_target  = uop.pc_target_src ? {r.alu_result[63:1], 1'b0} : uop.pc + uop.imm_ext;
    r.rd_addr    = uop.rd_addr;
    r.pc_src     = uop.jump | (uop.branch & branch_taken(uop.func3, uop.rs1_data, src_b));
    r.reg_we     = uop.reg_we;
    r.mem_we     = uop.mem_we;
    return r;
endfunction

`endif

//--- tests/tb_exec_cluster.sv
module tb_exec_cluster;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES      = 4;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_uop_valid;
    exec_pkg::uop_t         i_uop;
    logic                   o_uop_ready;
    logic                   o_res_valid;
    exec_pkg::exec_result_t o_res;
    logic                   i_res_ready;

    int errors;
    int checks;
    int tests_run;
    // 0 always ready, 1 random, 2 held low.
    int ready_mode;

    `include "exec_ref_model.svh"

    exec_cluster #(
        .NUM_LANES (NUM_LANES)
    ) dut_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_uop_valid (i_uop_valid),
        .i_uop       (i_uop),
        .o_uop_ready (o_uop_ready),
        .o_res_valid (o_res_valid),
        .o_res       (o_res),
        .i_res_ready (i_res_ready)
    );

    always #10 i_clk = ~i_clk;

    // --------------------------------------------------
    // helpers.
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles while waiting for %s", TIMEOUT_CYCLES, what);
        errors++;
        finish_run();
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        $display("test %-16s %s (%0d errors)", name,
                 (errors == errs_at_start) ? "ok" : "failed", errors - errs_at_start);
    endtask

    // random micro-op, either plain alu work or a branch or jump.
    function automatic exec_pkg::uop_t make_uop(input bit ctrl);
        exec_pkg::uop_t u;
        u.pc            = {$urandom(), $urandom()};
        u.rs1_data      = {$urandom(), $urandom()};
        u.rs2_data      = {$urandom(), $urandom()};
        u.imm_ext       = {$urandom(), $urandom()};
        u.rd_addr       = $urandom_range(0, 31);
        u.alu_op        = exec_pkg::alu_op_e'($urandom_range(0, 9));
        u.func3         = exec_pkg::branch_cond_e'($urandom_range(0, 7));
        u.alu_src       = $urandom_range(0, 1);
        u.branch        = 1'b0;
        u.jump          = 1'b0;
        u.pc_target_src = $urandom_range(0, 1);
        u.reg_we        = $urandom_range(0, 1);
        u.mem_we        = $urandom_range(0, 1);
        if (ctrl) begin
            if ($urandom_range(0, 3) == 0) begin
                u.jump   = 1'b1;
                u.alu_op = exec_pkg::ALU_ADD;
            end else begin
                u.branch  = 1'b1;
                u.alu_op  = exec_pkg::ALU_SUB;
                u.alu_src = 1'b0;
                case ($urandom_range(0, 5))
                    0: u.func3 = exec_pkg::BR_EQ;
                    1: u.func3 = exec_pkg::BR_NE;
                    2: u.func3 = exec_pkg::BR_LT;
                    3: u.func3 = exec_pkg::BR_GE;
                    4: u.func3 = exec_pkg::BR_LTU;
                    default: u.func3 = exec_pkg::BR_GEU;
                endcase
                if ($urandom_range(0, 1) == 1) begin
                    u.rs2_data = u.rs1_data;
                end
            end
        end
        return u;
    endfunction

    // holds the micro-op until the cluster accepts it.
    task automatic send_uop(input exec_pkg::uop_t uop);
        int cycles;
        cycles = 0;
        i_uop_valid <= 1'b1;
        i_uop       <= uop;
        do begin
            @(posedge i_clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                report_timeout("o_uop_ready");
            end
        end while (!o_uop_ready);
    endtask

    task automatic idle_cycle();
        i_uop_valid <= 1'b0;
        @(posedge i_clk);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        i_uop_valid <= 1'b0;
        do begin
            @(posedge i_clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                report_timeout("the pending results to drain");
            end
        end while (expected_q.size() != 0 || o_res_valid);
    endtask

    // keeps valid high until the input stalls.
    task automatic fill_until_stall(output int accepted);
        bit stalled;
        accepted = 0;
        stalled  = 1'b0;
        i_uop_valid <= 1'b1;
        i_uop       <= make_uop($urandom_range(0, 1));
        while (!stalled && accepted <= NUM_LANES) begin
            @(posedge i_clk);
            if (o_uop_ready) begin
                accepted++;
                i_uop <= make_uop($urandom_range(0, 1));
            end else begin
                stalled = 1'b1;
            end
        end
        i_uop_valid <= 1'b0;
        if (!stalled) begin
            $display("o_uop_ready stayed high after %0d micro-ops with output blocked",
                     accepted);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // output back-pressure.
    // --------------------------------------------------
    always @(posedge i_clk) begin
        case (ready_mode)
            0:       i_res_ready <= 1'b1;
            1:       i_res_ready <= $urandom_range(0, 1);
            default: i_res_ready <= 1'b0;
        endcase
    end

    // --------------------------------------------------
    // monitor and scoreboard.
    // --------------------------------------------------
    always @(posedge i_clk) begin
        exec_pkg::exec_result_t exp;
        if (!i_rst) begin
            if (!o_uop_ready && expected_q.size() == 0) begin
                $display("o_uop_ready low at %0t with no result pending", $time);
                errors++;
            end
            if (o_res_valid && i_res_ready) begin
                if (expected_q.size() == 0) begin
                    $display("result at %0t arrived with no micro-op pending", $time);
                    errors++;
                end else begin
                    exp = expected_q.pop_front();
                    check_value("alu_result", exp.alu_result, o_res.alu_result);
                    check_value("write_data", exp.write_data, o_res.write_data);
                    check_value("pc_plus4", exp.pc_plus4, o_res.pc_plus4);
                    check_value("pc_target", exp.pc_target, o_res.pc_target);
                    check_value("rd_addr", exp.rd_addr, o_res.rd_addr);
                    check_value("pc_src", exp.pc_src, o_res.pc_src);
                    check_value("reg_we", exp.reg_we, o_res.reg_we);
                    check_value("mem_we", exp.mem_we, o_res.mem_we);
                end
            end
            if (i_uop_valid && o_uop_ready) begin
                expected_q.push_back(expected_result(i_uop));
            end
        end
    end

    // --------------------------------------------------
    // test sequence.
    // --------------------------------------------------
    initial begin
        int start;
        int accepted;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        ready_mode  = 0;
        i_clk       = 1'b0;
        i_rst       = 1'b1;
        i_uop_valid = 1'b0;
        i_uop       = '0;
        i_res_ready = 1'b1;
        void'($urandom(57504));

        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);

        start = errors;
        check_value("o_res_valid", 64'd0, o_res_valid);
        check_value("o_uop_ready", 64'd1, o_uop_ready);
        end_test("reset", start);

        start = errors;
        for (int i = 0; i < 200; i++) begin
            send_uop(make_uop(1'b0));
        end
        wait_drained();
        end_test("alu ops", start);

        start = errors;
        for (int i = 0; i < 200; i++) begin
            send_uop(make_uop(1'b1));
        end
        wait_drained();
        end_test("branch and jump", start);

        // mixed traffic with gaps on both sides.
        start = errors;
        ready_mode <= 1;
        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                idle_cycle();
            end
            send_uop(make_uop($urandom_range(0, 1)));
        end
        ready_mode <= 0;
        wait_drained();
        end_test("back-pressure", start);

        // output blocked, the lanes fill and the input stalls.
        start = errors;
        ready_mode <= 2;
        repeat (2) @(posedge i_clk);
        fill_until_stall(accepted);
        if (accepted > NUM_LANES) begin
            $display("%0d micro-ops accepted with output blocked, limit is %0d",
                     accepted, NUM_LANES);
            errors++;
        end
        ready_mode <= 0;
        wait_drained();
        end_test("stall and drain", start);

        finish_run();
    end

endmodule

//--- verilog.f
+incdir+tests
design/exec_pkg.sv
design/alu.sv
design/exec_lane.sv
design/dispatch_unit.sv
design/result_merger.sv
design/exec_cluster.sv
tests/tb_exec_cluster.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - design/exec_pkg.sv
  - design/alu.sv
  - design/exec_lane.sv
  - design/dispatch_unit.sv
  - design/result_merger.sv
  - design/exec_cluster.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_exec_cluster.sv
